/* build.f */
+incdir+src
src/he_pkg.sv
src/he_regfile.sv
src/poly_alu.sv
src/ntt_unit.sv
src/op_sequencer.sv
src/he_core.sv
tests/he_core_tb.sv

/* Bender.yml */
package:
  name: he_core

sources:
  - include_dirs:
      - src
    files:
      - src/he_pkg.sv
      - src/he_regfile.sv
      - src/poly_alu.sv
      - src/ntt_unit.sv
      - src/op_sequencer.sv
      - src/he_core.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/he_core_tb.sv

/* tests/he_core_tb.sv */
`timescale 1ns/1ns
`include "he_macros.svh"

module he_core_tb;

  localparam int NTESTS   = 9;
  localparam int ADD_WAIT = 20;     // Cycles allowed for an add to retire
  localparam int MUL_WAIT = 400;    // Two full NTT round trips fit easily
  localparam int IDLE_WAIT = 10;

  logic              clk;
  logic              reset;
  logic              op_valid;
  he_pkg::op_e       op_mode;
  he_pkg::reg_idx_t  src0_idx;
  he_pkg::reg_idx_t  src1_idx;
  he_pkg::reg_idx_t  src2_idx;
  he_pkg::reg_idx_t  src3_idx;
  he_pkg::reg_idx_t  dst0_idx;
  he_pkg::reg_idx_t  dst1_idx;
  logic              load_en;
  he_pkg::reg_idx_t  load_idx;
  he_pkg::poly_t     load_poly;
  he_pkg::reg_idx_t  read_idx;
  logic              done;
  logic              busy;
  he_pkg::poly_t     read_poly;

  // ====================================================================
  //  Stimulus table with one column per array
  // ====================================================================
  string             t_name [NTESTS];
  he_pkg::op_e       t_op   [NTESTS];
  int                t_src  [NTESTS][4];
  int                t_dst  [NTESTS][2];
  int                t_load [NTESTS];   // 0 keep, 1 random fill, 2 random fill with src3 = 1
  int                t_lat  [NTESTS];   // Expected done latency or -1 when unchecked
  bit                t_poke [NTESTS];   // Second op_valid while busy
  int                row_n;

  he_pkg::poly_t     model_regs [`HE_NREGS];   // Expected register file contents
  integer            seed;
  int                pass_count;
  int                fail_count;
  int                errors;                   // Within the current test
  bit                timed_out;

  he_core dut0 (
    .clk(clk), .reset(reset), .op_valid(op_valid), .op_mode(op_mode),
    .src0_idx(src0_idx), .src1_idx(src1_idx), .src2_idx(src2_idx), .src3_idx(src3_idx),
    .dst0_idx(dst0_idx), .dst1_idx(dst1_idx),
    .load_en(load_en), .load_idx(load_idx), .load_poly(load_poly),
    .read_idx(read_idx), .done(done), .busy(busy), .read_poly(read_poly)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic int prime(input int lane);
    return (lane == 0) ? `HE_PRIME0 : `HE_PRIME1;
  endfunction

  function automatic he_pkg::poly_t add_model(input he_pkg::poly_t a, input he_pkg::poly_t b);
    he_pkg::poly_t r;
    for (int i = 0; i < `HE_N; i++) begin
      for (int l = 0; l < `HE_NPRIMES; l++) begin
        r[i][l] = he_pkg::residue_t'((int'(a[i][l]) + int'(b[i][l])) % prime(l));
      end
    end
    return r;
  endfunction

  // Schoolbook product mod x^N + 1 with the sign flipped on wrapped terms
  function automatic he_pkg::poly_t negmul_model(input he_pkg::poly_t a,
                                                 input he_pkg::poly_t b);
    he_pkg::poly_t r;
    int            acc;
    int            p;
    int            k;
    for (int l = 0; l < `HE_NPRIMES; l++) begin
      p = prime(l);
      for (int c = 0; c < `HE_N; c++) begin
        acc = 0;
        for (int i = 0; i < `HE_N; i++) begin
          k = c - i;                                          // Index into b
          if (k >= 0) acc += int'(a[i][l]) * int'(b[k][l]);
          else        acc += p * p - int'(a[i][l]) * int'(b[k + `HE_N][l]);  // Stays positive
        end
        r[c][l] = he_pkg::residue_t'(acc % p);
      end
    end
    return r;
  endfunction

  task automatic make_random(output he_pkg::poly_t p);
    for (int i = 0; i < `HE_N; i++) begin
      for (int l = 0; l < `HE_NPRIMES; l++) begin
        p[i][l] = he_pkg::residue_t'($unsigned($random(seed)) % prime(l));
      end
    end
  endtask

  task automatic add_row(input string name, input he_pkg::op_e op,
                         input int s0, input int s1, input int s2, input int s3,
                         input int d0, input int d1, input int load, input int lat,
                         input bit poke);
    t_name[row_n] = name;
    t_op[row_n]   = op;
    t_src[row_n]  = '{s0, s1, s2, s3};
    t_dst[row_n]  = '{d0, d1};
    t_load[row_n] = load;
    t_lat[row_n]  = lat;
    t_poke[row_n] = poke;
    row_n++;
  endtask

  // Tasks below start and end on a falling edge
  task automatic load_reg(input int idx, input he_pkg::poly_t p);
    load_en   = 1'b1;
    load_idx  = he_pkg::reg_idx_t'(idx);
    load_poly = p;
    @(negedge clk);
    load_en = 1'b0;
    model_regs[idx] = p;
  endtask

  task automatic check_reg(input string name, input int idx);
    read_idx = he_pkg::reg_idx_t'(idx);
    @(negedge clk);                             // Combinational read, stable a cycle later
    if (read_poly !== model_regs[idx]) begin
      $display("CHECK FAILED %s reg %0d expected %h actual %h",
               name, idx, model_regs[idx], read_poly);
      errors++;
    end
  endtask

  // ====================================================================
  //  Issue one instruction and wait for done and idle
  // ====================================================================
  task automatic run_op(input int t);
    int cycles;
    int limit;
    limit    = (t_op[t] == he_pkg::OP_CT_PT_MUL) ? MUL_WAIT : ADD_WAIT;
    op_valid = 1'b1;
    op_mode  = t_op[t];
    src0_idx = he_pkg::reg_idx_t'(t_src[t][0]);
    src1_idx = he_pkg::reg_idx_t'(t_src[t][1]);
    src2_idx = he_pkg::reg_idx_t'(t_src[t][2]);
    src3_idx = he_pkg::reg_idx_t'(t_src[t][3]);
    dst0_idx = he_pkg::reg_idx_t'(t_dst[t][0]);
    dst1_idx = he_pkg::reg_idx_t'(t_dst[t][1]);
    @(negedge clk);
    op_valid = 1'b0;
    cycles   = 0;
    if (t_poke[t]) begin
      repeat (3) @(negedge clk);
      cycles += 3;
      if (busy !== 1'b1) begin
        $display("%s: busy is low in the middle of the instruction", t_name[t]);
        errors++;
      end
      op_valid = 1'b1;                          // Must be dropped by the DUT
      op_mode  = he_pkg::OP_CT_CT_ADD;
      dst0_idx = he_pkg::reg_idx_t'(0);         // Rows keep 0 and 7 out of their dsts
      dst1_idx = he_pkg::reg_idx_t'(7);
      @(negedge clk);
      op_valid = 1'b0;
      cycles++;
    end
    while (done !== 1'b1 && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (done !== 1'b1) begin
      $display("%s: timeout, done never arrived within %0d cycles", t_name[t], limit);
      errors++;
      timed_out = 1'b1;
      return;
    end
    if (t_lat[t] >= 0 && cycles != t_lat[t]) begin
      $display("CHECK FAILED %s latency expected %0d actual %0d", t_name[t], t_lat[t], cycles);
      errors++;
    end
    @(negedge clk);
    if (done !== 1'b0) begin
      $display("%s: done stayed high for more than one cycle", t_name[t]);
      errors++;
    end
    cycles = 0;
    while (busy !== 1'b0 && cycles < IDLE_WAIT) begin
      @(negedge clk);
      cycles++;
    end
    if (busy !== 1'b0) begin
      $display("%s: timeout, busy never fell after done", t_name[t]);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  // Expected destinations from the register contents before the op
  task automatic predict(input int t);
    he_pkg::poly_t e0;
    he_pkg::poly_t e1;
    e0 = model_regs[t_src[t][0]];               // CT-PT ADD passes A through
    e1 = add_model(model_regs[t_src[t][1]], model_regs[t_src[t][3]]);
    if (t_op[t] == he_pkg::OP_CT_CT_ADD) begin
      e0 = add_model(model_regs[t_src[t][0]], model_regs[t_src[t][2]]);
    end else if (t_op[t] == he_pkg::OP_CT_PT_MUL && t_load[t] == 2) begin
      e1 = model_regs[t_src[t][1]];             // Times one leaves the ciphertext as is
    end else if (t_op[t] == he_pkg::OP_CT_PT_MUL) begin
      e0 = negmul_model(model_regs[t_src[t][0]], model_regs[t_src[t][3]]);
      e1 = negmul_model(model_regs[t_src[t][1]], model_regs[t_src[t][3]]);
    end
    model_regs[t_dst[t][0]] = e0;
    model_regs[t_dst[t][1]] = e1;
  endtask

  task automatic close_test(input string name);
    if (errors == 0) begin
      pass_count++;
      $display("%s: ok", name);
    end else begin
      fail_count++;
      $display("%s: %0d errors", name, errors);
    end
  endtask

  // ====================================================================
  //  Main sequence
  // ====================================================================
  initial begin
    he_pkg::poly_t p;
    he_pkg::poly_t one_poly;
    reset     = 1'b1;
    op_valid  = 1'b0;
    op_mode   = he_pkg::OP_NOP;
    src0_idx  = '0;
    src1_idx  = '0;
    src2_idx  = '0;
    src3_idx  = '0;
    dst0_idx  = '0;
    dst1_idx  = '0;
    load_en   = 1'b0;
    load_idx  = '0;
    load_poly = '0;
    read_idx  = '0;
    seed       = 40786;
    pass_count = 0;
    fail_count = 0;
    timed_out  = 1'b0;
    row_n      = 0;
    model_regs = '{default: '0};
    one_poly       = '0;
    one_poly[0][0] = 1;
    one_poly[0][1] = 1;

    //      name            op                      s0 s1 s2 s3 d0 d1 ld lat poke
    add_row("load_readback", he_pkg::OP_NOP,        0, 0, 0, 0, 0, 0, 1, -1, 0);
    add_row("ct_ct_add",     he_pkg::OP_CT_CT_ADD,  0, 1, 2, 3, 4, 5, 0,  2, 0);
    add_row("ct_pt_add",     he_pkg::OP_CT_PT_ADD,  0, 1, 2, 3, 6, 7, 0,  2, 0);
    add_row("ct_pt_mul",     he_pkg::OP_CT_PT_MUL,  0, 1, 2, 3, 4, 5, 1, -1, 0);
    add_row("mul_by_one",    he_pkg::OP_CT_PT_MUL,  0, 1, 2, 3, 6, 7, 2, -1, 0);
    add_row("busy_ignore",   he_pkg::OP_CT_PT_MUL,  2, 3, 0, 4, 5, 6, 1, -1, 1);
    add_row("alias_add",     he_pkg::OP_CT_CT_ADD,  0, 1, 2, 3, 0, 1, 0,  2, 0);
    add_row("alias_pt_add",  he_pkg::OP_CT_PT_ADD,  2, 3, 0, 3, 3, 2, 1,  2, 0);
    add_row("alias_mul",     he_pkg::OP_CT_PT_MUL,  4, 5, 0, 6, 6, 4, 1, -1, 0);

    repeat (5) @(negedge clk);
    reset  = 1'b0;
    errors = 0;
    if (busy !== 1'b0) begin
      $display("reset_state: busy is high after reset");
      errors++;
    end
    for (int r = 0; r < `HE_NREGS; r++) check_reg("reset_state", r);
    @(negedge clk);
    close_test("reset_state");

    for (int t = 0; t < NTESTS && !timed_out; t++) begin
      errors = 0;
      if (t_load[t] != 0) begin
        for (int r = 0; r < `HE_NREGS; r++) begin
          make_random(p);
          if (t_load[t] == 2 && r == t_src[t][3]) p = one_poly;   // Plaintext 1
          load_reg(r, p);
        end
      end
      if (t_op[t] != he_pkg::OP_NOP) begin
        run_op(t);
        predict(t);
      end
      if (!timed_out) begin
        for (int r = 0; r < `HE_NREGS; r++) check_reg(t_name[t], r);  // Whole file
        @(negedge clk);
      end
      close_test(t_name[t]);
    end

    $display("tests passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0 && !timed_out) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* src/he_core.sv */
`timescale 1ns/1ns

module he_core (
  input  logic              clk,
  input  logic              reset,
  input  logic              op_valid,
  input  he_pkg::op_e       op_mode,
  input  he_pkg::reg_idx_t  src0_idx,
  input  he_pkg::reg_idx_t  src1_idx,
  input  he_pkg::reg_idx_t  src2_idx,
  input  he_pkg::reg_idx_t  src3_idx,
  input  he_pkg::reg_idx_t  dst0_idx,
  input  he_pkg::reg_idx_t  dst1_idx,
  input  logic              load_en,
  input  he_pkg::reg_idx_t  load_idx,
  input  he_pkg::poly_t     load_poly,
  input  he_pkg::reg_idx_t  read_idx,
  output logic              done,
  output logic              busy,
  output he_pkg::poly_t     read_poly
);

  logic           issue;
  he_pkg::op_e    issue_mode;
  he_pkg::poly_t  src_poly0, src_poly1, src_poly2, src_poly3;
  he_pkg::poly_t  alu_a0, alu_b0, alu_a1, alu_b1, alu_y0, alu_y1;
  logic           alu_mul;
  logic           ntt0_start, ntt1_start, ntt_inverse, ntt0_ready, ntt1_ready;
  he_pkg::poly_t  ntt0_in, ntt1_in, ntt0_out, ntt1_out;
  logic           wr0_en, wr1_en;
  he_pkg::poly_t  wr0_poly, wr1_poly;

  // Input side, decode and operand read
  he_regfile u_regfile (
    .clk(clk), .reset(reset), .op_valid(op_valid), .op_mode(op_mode),
    .src0_idx(src0_idx), .src1_idx(src1_idx), .src2_idx(src2_idx), .src3_idx(src3_idx),
    .dst0_idx(dst0_idx), .dst1_idx(dst1_idx),
    .load_en(load_en), .load_idx(load_idx), .load_poly(load_poly),
    .read_idx(read_idx), .read_poly(read_poly),
    .done(done), .wr0_en(wr0_en), .wr1_en(wr1_en), .wr0_poly(wr0_poly), .wr1_poly(wr1_poly),
    .issue(issue), .issue_mode(issue_mode),
    .src_poly0(src_poly0), .src_poly1(src_poly1), .src_poly2(src_poly2),
    .src_poly3(src_poly3), .busy(busy)
  );

  op_sequencer u_seq (
    .clk(clk), .reset(reset), .issue(issue), .issue_mode(issue_mode),
    .src_poly0(src_poly0), .src_poly1(src_poly1), .src_poly2(src_poly2),
    .src_poly3(src_poly3),
    .alu_a0(alu_a0), .alu_b0(alu_b0), .alu_a1(alu_a1), .alu_b1(alu_b1), .alu_mul(alu_mul),
    .alu_y0(alu_y0), .alu_y1(alu_y1),
    .ntt0_start(ntt0_start), .ntt1_start(ntt1_start), .ntt_inverse(ntt_inverse),
    .ntt0_in(ntt0_in), .ntt1_in(ntt1_in), .ntt0_out(ntt0_out), .ntt1_out(ntt1_out),
    .ntt0_ready(ntt0_ready), .ntt1_ready(ntt1_ready),
    .wr0_en(wr0_en), .wr1_en(wr1_en), .wr0_poly(wr0_poly), .wr1_poly(wr1_poly),
    .done(done)
  );

  poly_alu u_alu (
    .a0(alu_a0), .b0(alu_b0), .a1(alu_a1), .b1(alu_b1), .mul(alu_mul),
    .y0(alu_y0), .y1(alu_y1)
  );

  // Unit 0 ciphertext half, unit 1 plaintext
  ntt_unit u_ntt0 (
    .clk(clk), .reset(reset), .start(ntt0_start), .inverse(ntt_inverse),
    .data_in(ntt0_in), .data_out(ntt0_out), .ready(ntt0_ready)
  );

  ntt_unit u_ntt1 (
    .clk(clk), .reset(reset), .start(ntt1_start), .inverse(ntt_inverse),
    .data_in(ntt1_in), .data_out(ntt1_out), .ready(ntt1_ready)
  );

endmodule

/* src/op_sequencer.sv */
`timescale 1ns/1ns

module op_sequencer (
  input  logic           clk,
  input  logic           reset,
  input  logic           issue,
  input  he_pkg::op_e    issue_mode,
  input  he_pkg::poly_t  src_poly0,   // CT A part
  input  he_pkg::poly_t  src_poly1,   // CT B part
  input  he_pkg::poly_t  src_poly2,
  input  he_pkg::poly_t  src_poly3,   // Plaintext or second B
  output he_pkg::poly_t  alu_a0,
  output he_pkg::poly_t  alu_b0,
  output he_pkg::poly_t  alu_a1,
  output he_pkg::poly_t  alu_b1,
  output logic           alu_mul,
  input  he_pkg::poly_t  alu_y0,
  input  he_pkg::poly_t  alu_y1,
  output logic           ntt0_start,
  output logic           ntt1_start,
  output logic           ntt_inverse,
  output he_pkg::poly_t  ntt0_in,
  output he_pkg::poly_t  ntt1_in,
  input  he_pkg::poly_t  ntt0_out,
  input  he_pkg::poly_t  ntt1_out,
  input  logic           ntt0_ready,
  input  logic           ntt1_ready,
  output logic           wr0_en,
  output logic           wr1_en,
  output he_pkg::poly_t  wr0_poly,
  output he_pkg::poly_t  wr1_poly,
  output logic           done
);

  localparam he_pkg::poly_t TWIST   = he_pkg::twist_poly();
  localparam he_pkg::poly_t UNTWIST = he_pkg::untwist_poly();

  he_pkg::stage_e  stage_q;
  logic            half_q;       // 0 A pass, 1 B pass
  he_pkg::poly_t   scratch0;     // Ciphertext half through the pipeline
  he_pkg::poly_t   scratch1;     // Twisted plaintext
  logic            add_issue;

  assign add_issue = stage_q == he_pkg::ST_IDLE && issue &&
                     (issue_mode == he_pkg::OP_CT_CT_ADD || issue_mode == he_pkg::OP_CT_PT_ADD);

  // ======================================================================
  //  Operand muxing
  // ======================================================================
  always_comb begin
    alu_a0  = src_poly0;         // CT-CT ADD layout by default
    alu_b0  = src_poly2;
    alu_a1  = src_poly1;
    alu_b1  = src_poly3;
    alu_mul = 1'b0;
    case (stage_q)
      he_pkg::ST_IDLE: begin
        if (issue_mode == he_pkg::OP_CT_PT_ADD) alu_b0 = '0;  // A passes through
      end
      he_pkg::ST_TWIST: begin
        alu_a0  = half_q ? src_poly1 : src_poly0;
        alu_b0  = TWIST;
        alu_a1  = src_poly3;
        alu_b1  = TWIST;
        alu_mul = 1'b1;
      end
      he_pkg::ST_POINTWISE: begin
        alu_a0  = ntt0_out;      // Both units hold results until next start
        alu_b0  = ntt1_out;
        alu_mul = 1'b1;
      end
      he_pkg::ST_UNTWIST: begin
        alu_a0  = ntt0_out;
        alu_b0  = UNTWIST;
        alu_mul = 1'b1;
      end
      default: ;
    endcase
  end

  assign ntt0_in     = scratch0;
  assign ntt1_in     = scratch1;
  assign ntt0_start  = stage_q == he_pkg::ST_NTT_FWD || stage_q == he_pkg::ST_NTT_INV;
  assign ntt1_start  = stage_q == he_pkg::ST_NTT_FWD;  // Inverse only needs unit 0
  assign ntt_inverse = stage_q == he_pkg::ST_NTT_INV;

  // Adds write straight from the ALU in the issue cycle
  assign wr0_en   = add_issue || (stage_q == he_pkg::ST_WRITE && !half_q);
  assign wr1_en   = add_issue || (stage_q == he_pkg::ST_WRITE && half_q);
  assign wr0_poly = (stage_q == he_pkg::ST_WRITE) ? scratch0 : alu_y0;
  assign wr1_poly = (stage_q == he_pkg::ST_WRITE) ? scratch0 : alu_y1;

  // ======================================================================
  //  Stage FSM
  // ======================================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      stage_q <= he_pkg::ST_IDLE;
      half_q  <= 1'b0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      case (stage_q)
        he_pkg::ST_IDLE: begin
          if (issue) begin
            if (issue_mode == he_pkg::OP_CT_PT_MUL) begin
              stage_q <= he_pkg::ST_TWIST;
              half_q  <= 1'b0;
            end else begin
              stage_q <= he_pkg::ST_ADD;   // NOP also retires here
              done    <= 1'b1;
            end
          end
        end
        he_pkg::ST_ADD:       stage_q <= he_pkg::ST_IDLE;
        he_pkg::ST_TWIST:     stage_q <= he_pkg::ST_NTT_FWD;
        he_pkg::ST_NTT_FWD:   stage_q <= he_pkg::ST_NTT_WAIT_F;
        he_pkg::ST_NTT_WAIT_F: begin
          if (ntt0_ready && ntt1_ready) stage_q <= he_pkg::ST_POINTWISE;
        end
        he_pkg::ST_POINTWISE: stage_q <= he_pkg::ST_NTT_INV;
        he_pkg::ST_NTT_INV:   stage_q <= he_pkg::ST_NTT_WAIT_I;
        he_pkg::ST_NTT_WAIT_I: begin
          if (ntt0_ready) stage_q <= he_pkg::ST_UNTWIST;
        end
        he_pkg::ST_UNTWIST:   stage_q <= he_pkg::ST_WRITE;
        he_pkg::ST_WRITE: begin
          if (half_q) begin
            stage_q <= he_pkg::ST_IDLE;
            done    <= 1'b1;
          end else begin
            half_q  <= 1'b1;               // Rerun for B part
            stage_q <= he_pkg::ST_TWIST;
          end
        end
        default: stage_q <= he_pkg::ST_IDLE;
      endcase
    end
  end

  // Scratch between stages
  always_ff @(posedge clk) begin
    case (stage_q)
      he_pkg::ST_TWIST: begin
        scratch0 <= alu_y0;
        scratch1 <= alu_y1;
      end
      he_pkg::ST_POINTWISE, he_pkg::ST_UNTWIST: scratch0 <= alu_y0;
      default: ;
    endcase
  end

  // Retirement paths only
  a_idle_entry: assert property (@(posedge clk) disable iff (reset)
    (stage_q == he_pkg::ST_IDLE && $past(stage_q) != he_pkg::ST_IDLE)
      |-> $past(stage_q) inside {he_pkg::ST_ADD, he_pkg::ST_WRITE});

endmodule

/* src/ntt_unit.sv */
`timescale 1ns/1ns
`include "he_macros.svh"

module ntt_unit (
  input  logic           clk,
  input  logic           reset,
  input  logic           start,
  input  logic           inverse,
  input  he_pkg::poly_t  data_in,
  output he_pkg::poly_t  data_out,
  output logic           ready
);

  localparam int STG_W = $clog2(`HE_LOG_N);
  localparam int BF_W  = $clog2(`HE_N / 2);

  he_pkg::poly_t     buf_q;     // In-place working set
  he_pkg::poly_t     buf_d;
  logic              inv_q;
  logic              running_q;
  logic [STG_W-1:0]  stage_q;
  logic [BF_W-1:0]   bfly_q;    // Butterfly within the stage

  function automatic int bit_rev(input int x);
    int r;
    r = 0;
    for (int b = 0; b < `HE_LOG_N; b++) begin
      r[`HE_LOG_N-1-b] = x[b];
    end
    return r;
  endfunction

  // ======================================================================
  //  One butterfly per cycle, DIF layout, both primes side by side
  // ======================================================================
  always_comb begin : bfly_comb
    int sh;
    int j;
    int i0;
    int i1;
    int k;
    int p;
    int u;
    int v;
    int w;
    sh = `HE_LOG_N - 1 - int'(stage_q);
    j  = int'(bfly_q) & ((1 << sh) - 1);         // Offset inside group
    i0 = ((int'(bfly_q) >> sh) << (sh + 1)) | j;
    i1 = i0 + (1 << sh);                         // Span halves each stage
    k  = j << stage_q;                           // omega exponent
    buf_d = buf_q;
    for (int l = 0; l < `HE_NPRIMES; l++) begin
      p = he_pkg::prime_of(l);
      u = int'(buf_q[i0][l]);
      v = int'(buf_q[i1][l]);
      w = 0;
      for (int kk = 0; kk < `HE_N / 2; kk++) begin
        if (kk == k) w = inverse_sel(l, kk);
      end
      buf_d[i0][l] = he_pkg::residue_t'((u + v) % p);
      buf_d[i1][l] = he_pkg::residue_t'(((u + p - v) * w) % p);
    end
  end

  function automatic int inverse_sel(input int lane, input int kk);
    return inv_q ? int'(he_pkg::twiddle(lane, kk, 1'b1))
                 : int'(he_pkg::twiddle(lane, kk, 1'b0));
  endfunction

  // DIF leaves bit-reversed order, undo on the way out
  always_comb begin
    for (int i = 0; i < `HE_N; i++) begin
      data_out[i] = buf_q[bit_rev(i)];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      running_q <= 1'b0;
      ready     <= 1'b0;
      stage_q   <= '0;
      bfly_q    <= '0;
    end else begin
      ready <= 1'b0;
      if (start) begin
        running_q <= 1'b1;
        stage_q   <= '0;
        bfly_q    <= '0;
      end else if (running_q) begin
        bfly_q <= bfly_q + 1'b1;                    // Wraps per stage
        if (bfly_q == BF_W'(`HE_N / 2 - 1)) begin
          stage_q <= stage_q + 1'b1;
          if (stage_q == STG_W'(`HE_LOG_N - 1)) begin
            running_q <= 1'b0;
            ready     <= 1'b1;                      // Single pulse
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      buf_q <= data_in;
      inv_q <= inverse;
    end else if (running_q) begin
      buf_q <= buf_d;
    end
  end

  // Sequencer must wait for ready before the next transform
  a_no_restart: assert property (@(posedge clk) disable iff (reset)
    start |-> !running_q);

endmodule

/* src/poly_alu.sv */
`timescale 1ns/1ns
`include "he_macros.svh"

module poly_alu (
  input  he_pkg::poly_t  a0,
  input  he_pkg::poly_t  b0,
  input  he_pkg::poly_t  a1,
  input  he_pkg::poly_t  b1,
  input  logic           mul,   // 1 product, 0 sum
  output he_pkg::poly_t  y0,
  output he_pkg::poly_t  y1
);

  // One lane, coefficient-wise over every prime
  function automatic he_pkg::poly_t lane_op(input he_pkg::poly_t a,
                                            input he_pkg::poly_t b,
                                            input logic do_mul);
    he_pkg::poly_t r;
    int            p;
    int            x;
    for (int i = 0; i < `HE_N; i++) begin
      for (int l = 0; l < `HE_NPRIMES; l++) begin
        p = he_pkg::prime_of(l);
        if (do_mul) x = int'(a[i][l]) * int'(b[i][l]);   // Below 97*97
        else        x = int'(a[i][l]) + int'(b[i][l]);
        r[i][l] = he_pkg::residue_t'(x % p);
      end
    end
    return r;
  endfunction

  // Lane 0 A part or ciphertext half, lane 1 B part or plaintext
  assign y0 = lane_op(a0, b0, mul);
  assign y1 = lane_op(a1, b1, mul);

endmodule

/* src/he_regfile.sv */
`timescale 1ns/1ns
`include "he_macros.svh"

module he_regfile (
  input  logic              clk,
  input  logic              reset,
  input  logic              op_valid,
  input  he_pkg::op_e       op_mode,
  input  he_pkg::reg_idx_t  src0_idx,
  input  he_pkg::reg_idx_t  src1_idx,
  input  he_pkg::reg_idx_t  src2_idx,
  input  he_pkg::reg_idx_t  src3_idx,
  input  he_pkg::reg_idx_t  dst0_idx,
  input  he_pkg::reg_idx_t  dst1_idx,
  input  logic              load_en,
  input  he_pkg::reg_idx_t  load_idx,
  input  he_pkg::poly_t     load_poly,
  input  he_pkg::reg_idx_t  read_idx,
  output he_pkg::poly_t     read_poly,
  input  logic              done,
  input  logic              wr0_en,
  input  logic              wr1_en,
  input  he_pkg::poly_t     wr0_poly,
  input  he_pkg::poly_t     wr1_poly,
  output logic              issue,
  output he_pkg::op_e       issue_mode,
  output he_pkg::poly_t     src_poly0,
  output he_pkg::poly_t     src_poly1,
  output he_pkg::poly_t     src_poly2,
  output he_pkg::poly_t     src_poly3,
  output logic              busy
);

  he_pkg::poly_t     regs [`HE_NREGS];
  he_pkg::reg_idx_t  src_idx_q [4];       // Latched source indexes
  he_pkg::reg_idx_t  dst0_q;
  he_pkg::reg_idx_t  dst1_q;
  logic              accept_q;            // Instruction taken last edge
  logic              accept;

  assign accept    = op_valid && !busy;
  assign read_poly = regs[read_idx];      // Observation port, no latency

  // ======================================================================
  //  Control and register writes
  // ======================================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      regs       <= '{default: '0};
      busy       <= 1'b0;
      accept_q   <= 1'b0;
      issue      <= 1'b0;
      issue_mode <= he_pkg::OP_NOP;
    end else begin
      accept_q <= accept;
      issue    <= accept_q;               // Operands valid with this strobe
      if (accept) begin
        busy       <= 1'b1;
        issue_mode <= op_mode;
      end else if (done) begin
        busy <= 1'b0;
      end
      if (load_en && !busy) regs[load_idx] <= load_poly;
      // Results, dst1 wins on equal indexes
      if (wr0_en) regs[dst0_q] <= wr0_poly;
      if (wr1_en) regs[dst1_q] <= wr1_poly;
    end
  end

  // Index latch and operand read
  always_ff @(posedge clk) begin
    if (accept) begin
      src_idx_q[0] <= src0_idx;
      src_idx_q[1] <= src1_idx;
      src_idx_q[2] <= src2_idx;
      src_idx_q[3] <= src3_idx;
      dst0_q       <= dst0_idx;
      dst1_q       <= dst1_idx;
    end
    // Snapshot before any write, keeps aliased sources intact
    if (accept_q) begin
      src_poly0 <= regs[src_idx_q[0]];
      src_poly1 <= regs[src_idx_q[1]];
      src_poly2 <= regs[src_idx_q[2]];
      src_poly3 <= regs[src_idx_q[3]];
    end
  end

  // No back-pressure: host must hold off commands and loads until done
  a_idle_cmds: assert property (@(posedge clk) disable iff (reset)
    busy |-> !op_valid && !load_en)
    else $warning("op_valid or load_en while busy, request dropped");

endmodule

/* src/he_pkg.sv */
`include "he_macros.svh"

package he_pkg;

  typedef enum logic [1:0] {
    OP_NOP,
    OP_CT_CT_ADD,
    OP_CT_PT_ADD,
    OP_CT_PT_MUL
  } op_e;

  // Sequencer stages, CT-PT MUL runs TWIST..WRITE once per ciphertext half
  typedef enum logic [3:0] {
    ST_IDLE,
    ST_ADD,
    ST_TWIST,
    ST_NTT_FWD,
    ST_NTT_WAIT_F,
    ST_POINTWISE,
    ST_NTT_INV,
    ST_NTT_WAIT_I,
    ST_UNTWIST,
    ST_WRITE
  } stage_e;

  typedef logic [`HE_RES_BITS-1:0]     residue_t;
  typedef residue_t [`HE_NPRIMES-1:0]  rns_coef_t;  // [lane]
  typedef rns_coef_t [`HE_N-1:0]       poly_t;      // [coef][lane]
  typedef logic [`HE_REG_BITS-1:0]     reg_idx_t;

  function automatic int prime_of(input int lane);
    return (lane == 0) ? `HE_PRIME0 : `HE_PRIME1;
  endfunction

  // Square and multiply, exponents below 256
  function automatic int mod_pow(input int base, input int expo, input int m);
    int acc;
    int b;
    acc = 1;
    b   = base % m;
    for (int i = 0; i < 8; i++) begin
      if (expo[i]) acc = (acc * b) % m;
      b = (b * b) % m;
    end
    return acc;
  endfunction

  // Primitive 2N-th root, from generators 3 (mod 17) and 5 (mod 97)
  function automatic int psi_of(input int lane);
    int g;
    g = (lane == 0) ? 3 : 5;
    return mod_pow(g, (prime_of(lane) - 1) / (2 * `HE_N), prime_of(lane));
  endfunction

  function automatic poly_t twist_poly();
    poly_t t;
    for (int i = 0; i < `HE_N; i++) begin
      for (int l = 0; l < `HE_NPRIMES; l++) begin
        t[i][l] = residue_t'(mod_pow(psi_of(l), i, prime_of(l)));
      end
    end
    return t;
  endfunction

  // psi^-i folded with 1/N, so the inverse NTT needs no extra scaling
  function automatic poly_t untwist_poly();
    poly_t t;
    int    p;
    int    n_inv;
    for (int l = 0; l < `HE_NPRIMES; l++) begin
      p     = prime_of(l);
      n_inv = mod_pow(`HE_N, p - 2, p);   // Fermat inverse
      for (int i = 0; i < `HE_N; i++) begin
        t[i][l] = residue_t'((mod_pow(psi_of(l), 2 * `HE_N - i, p) * n_inv) % p);
      end
    end
    return t;
  endfunction

  // omega = psi^2, inverse twiddle is omega^(N-k)
  function automatic residue_t twiddle(input int lane, input int k, input logic inverse);
    int p;
    int w;
    p = prime_of(lane);
    w = mod_pow(psi_of(lane), 2, p);
    return residue_t'(mod_pow(w, inverse ? (`HE_N - k) % `HE_N : k, p));
  endfunction

endpackage

/* src/he_macros.svh */
`ifndef HE_MACROS_SVH
`define HE_MACROS_SVH

// Polynomial geometry
`define HE_N        8   // Coefficients per polynomial
`define HE_LOG_N    3   // NTT stages

// RNS base, one lane per prime
`define HE_NPRIMES  2
`define HE_PRIME0   17
`define HE_PRIME1   97
`define HE_RES_BITS 7   // Wide enough for residues below 97

// Register file
`define HE_NREGS    8
`define HE_REG_BITS 3

`endif
